/* verilog/roadf_pkg.sv */
package roadf_pkg;

    // SDRAM is addressed in 16-bit words
    localparam int sdram_aw = 22;
    // Download stream is addressed in bytes
    localparam int ioctl_aw = 25;

    // SDRAM map in words
    // Main CPU ROM sits at word 0, 64kB
    localparam logic [sdram_aw-1:0] snd_start = 22'h00_8000; // 8kB sound CPU ROM
    localparam logic [sdram_aw-1:0] scr_start = 22'h00_9000; // 32kB scroll tiles

    // First byte past the scroll region in the download stream
    // Colour PROMs from here on never reach the SDRAM
    localparam logic [ioctl_aw-1:0] prom_start = 25'h01_A000;

    // ROM payloads as seen by each client
    typedef logic [ 7:0] cpu_data_t;   // One opcode or operand byte
    typedef logic [31:0] scr_data_t;   // Eight 4bpp pixels of a tile row

endpackage

/* verilog/roadf_frac_cen.sv */
`timescale 1ns/100ps

module roadf_frac_cen(
    input        clk,
    input        rst,
    input        vsync60,   // Selects the 60Hz pixel rate
    output logic pxl2_cen,
    output logic pxl_cen
);

logic [9:0] n, m;
logic [9:0] acc, sum;
logic       over;
logic       tog;

// 1/4 of clk for the 60Hz timing, 32/125 for the original rate
assign n = vsync60 ? 10'd1 : 10'd32;
assign m = vsync60 ? 10'd4 : 10'd125;

assign sum  = acc + n;
assign over = sum >= m;

always_ff @(posedge clk) begin
    if (rst) begin
        acc      <= '0;
        tog      <= 1'b0;
        pxl2_cen <= 1'b0;
        pxl_cen  <= 1'b0;
    end else begin
        acc      <= over ? sum - m : sum;
        pxl2_cen <= over;
        // Half rate enable lands on every second pxl2_cen
        pxl_cen  <= over & tog;
        if (over) begin
            tog <= ~tog;
        end
    end
end

endmodule

/* verilog/roadf_dwnld.sv */
`timescale 1ns/100ps

module roadf_dwnld #(
    parameter logic [roadf_pkg::ioctl_aw-1:0] PROM_START = '0,
    parameter logic [roadf_pkg::sdram_aw-1:0] SCR_START  = '0,
    parameter logic [roadf_pkg::sdram_aw-1:0] SCR_END    = '0
)(
    input                                   clk,
    input                                   rst,
    input                                   downloading,
    input        [roadf_pkg::ioctl_aw-1:0]  ioctl_addr,
    input        [7:0]                      ioctl_dout,
    input                                   ioctl_wr,
    input                                   sdram_ack,
    output logic [roadf_pkg::sdram_aw-1:0]  prog_addr,
    output logic [7:0]                      prog_data,
    output logic [1:0]                      prog_mask,  // Active low
    output logic                            prog_we,
    output logic                            prom_we,
    output logic                            dwnld_busy
);

import roadf_pkg::*;

logic [sdram_aw-1:0] word_addr;
logic [sdram_aw-1:0] scr_addr;
logic [ioctl_aw-1:0] prom_ofs;
logic                is_prom;
logic                is_scr;

assign word_addr = ioctl_addr[sdram_aw:1];
assign prom_ofs  = ioctl_addr - PROM_START;
assign is_prom   = ioctl_addr >= PROM_START;
assign is_scr    = word_addr >= SCR_START && word_addr < SCR_END;

// Scroll tiles are stored with the row halves interleaved
assign scr_addr = { word_addr[sdram_aw-1:4], word_addr[2:0], ~word_addr[3] };

assign dwnld_busy = downloading;

// Payload of the write, loaded on every byte
always_ff @(posedge clk) begin
    if (ioctl_wr) begin
        prog_data <= ioctl_dout;
        // Byte swap, so even bytes go to the upper half
        prog_mask <= { ioctl_addr[0], ~ioctl_addr[0] };
        if (is_prom) begin
            prog_addr <= prom_ofs[sdram_aw-1:0];   // Offset inside the PROM area
        end else begin
            prog_addr <= is_scr ? scr_addr : word_addr;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        prog_we <= 1'b0;
        prom_we <= 1'b0;
    end else begin
        prom_we <= ioctl_wr & is_prom; // Single cycle strobe
        if (ioctl_wr && !is_prom) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;           // SDRAM took it
        end
    end
end

// Stream must leave time for the SDRAM to take each byte before the PROMs start
a_we_excl: assert property (@(posedge clk) disable iff (rst) !(prog_we && prom_we));

endmodule

/* verilog/roadf_rom_slot.sv */
`timescale 1ns/100ps

module roadf_rom_slot #(
    parameter int                             AW     = 16,
    parameter logic [roadf_pkg::sdram_aw-1:0] OFFSET = '0,
    parameter type                            data_t = logic [7:0]
)(
    input                                   clk,
    input                                   rst,
    // Client side
    input                                   cs,
    input        [AW-1:0]                   addr,
    output data_t                           data,
    output logic                            ok,
    // Arbiter side
    output logic                            req,
    output logic [roadf_pkg::sdram_aw-1:0]  req_addr,
    input                                   gnt,
    input        [15:0]                     data_read,
    input                                   data_dst,
    input                                   data_rdy
);

import roadf_pkg::*;

localparam int DW = $bits(data_t);
localparam int NI = 32 / DW;       // Items held by one 32-bit line

logic [AW-1:0] line_idx;
logic [AW-1:0] item;
logic [AW-1:0] tag, pend_tag;
logic [31:0]   line;
logic [15:0]   first;      // Lower word while the second one is on its way
logic          valid;
logic          hit;

assign line_idx = addr / AW'(NI);
assign item     = addr % AW'(NI);

assign hit  = valid && tag == line_idx;
assign ok   = cs && hit;
assign data = data_t'(line >> (DW * item));

// Miss goes to the arbiter, two SDRAM words per line
assign req      = cs && !hit;
assign req_addr = OFFSET + sdram_aw'({ line_idx, 1'b0 });

always_ff @(posedge clk) begin
    // Tracks the address until the arbiter takes it
    if (!gnt) begin
        pend_tag <= line_idx;
    end
    if (gnt && data_dst) begin
        if (data_rdy) begin
            line <= { data_read, first };
        end else begin
            first <= data_read;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        valid <= 1'b0;
        tag   <= '0;
    end else if (gnt && data_rdy) begin
        valid <= 1'b1;
        tag   <= pend_tag;
    end
end

a_ok_valid: assert property (@(posedge clk) disable iff (rst) ok |-> valid);

endmodule

/* verilog/roadf_rom_arb.sv */
`timescale 1ns/100ps

module roadf_rom_arb(
    input                                   clk,
    input                                   rst,
    input                                   downloading,
    input                                   main_req,
    input        [roadf_pkg::sdram_aw-1:0]  main_addr,
    input                                   snd_req,
    input        [roadf_pkg::sdram_aw-1:0]  snd_addr,
    input                                   scr_req,
    input        [roadf_pkg::sdram_aw-1:0]  scr_addr,
    output logic                            main_gnt,
    output logic                            snd_gnt,
    output logic                            scr_gnt,
    output logic                            sdram_req,
    output logic [roadf_pkg::sdram_aw-1:0]  sdram_addr,
    input                                   sdram_ack,
    input                                   data_rdy
);

import roadf_pkg::*;

typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_xfer
} state_t;

state_t              st;
logic [2:0]          pick;
logic [sdram_aw-1:0] pick_addr;

// Main CPU first, then sound, then scroll
always_comb begin
    pick      = 3'b000;
    pick_addr = scr_addr;
    if (main_req) begin
        pick      = 3'b001;
        pick_addr = main_addr;
    end else if (snd_req) begin
        pick      = 3'b010;
        pick_addr = snd_addr;
    end else if (scr_req) begin
        pick = 3'b100;
    end
end

always_ff @(posedge clk) begin
    if (st == st_idle) begin
        sdram_addr <= pick_addr;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        st        <= st_idle;
        sdram_req <= 1'b0;
        { scr_gnt, snd_gnt, main_gnt } <= 3'b000;
    end else begin
        case (st)
            st_idle: begin
                // No new reads while the ROMs are being loaded
                if (!downloading && pick != 3'b000) begin
                    st        <= st_req;
                    sdram_req <= 1'b1;
                    { scr_gnt, snd_gnt, main_gnt } <= pick;
                end
            end
            st_req: begin
                if (sdram_ack) begin
                    st        <= st_xfer;
                    sdram_req <= 1'b0;
                end
            end
            st_xfer: begin
                if (data_rdy) begin   // Second word is in
                    st <= st_idle;
                    { scr_gnt, snd_gnt, main_gnt } <= 3'b000;
                end
            end
            default: st <= st_idle;
        endcase
    end
end

a_one_gnt: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ main_gnt, snd_gnt, scr_gnt }));

endmodule

/* verilog/roadf_game.sv */
`timescale 1ns/100ps

module roadf_game #(
    parameter int MAIN_AW = 16,
    parameter int SND_AW  = 13,
    parameter int SCR_AW  = 13
)(
    input                                   clk,
    input                                   rst,
    input                                   vsync60,
    output                                  pxl2_cen,
    output                                  pxl_cen,
    // ROM download
    input                                   downloading,
    output                                  dwnld_busy,
    input        [roadf_pkg::ioctl_aw-1:0]  ioctl_addr,
    input        [7:0]                      ioctl_dout,
    input                                   ioctl_wr,
    output       [roadf_pkg::sdram_aw-1:0]  prog_addr,
    output       [7:0]                      prog_data,
    output       [1:0]                      prog_mask,
    output                                  prog_we,
    output                                  prom_we,
    // Main CPU ROM
    input                                   main_cs,
    input        [MAIN_AW-1:0]              main_addr,
    output roadf_pkg::cpu_data_t            main_data,
    output                                  main_ok,
    // Sound CPU ROM
    input                                   snd_cs,
    input        [SND_AW-1:0]               snd_addr,
    output roadf_pkg::cpu_data_t            snd_data,
    output                                  snd_ok,
    // Scroll ROM
    input                                   scr_cs,
    input        [SCR_AW-1:0]               scr_addr,
    output roadf_pkg::scr_data_t            scr_data,
    output                                  scr_ok,
    // SDRAM
    output                                  sdram_req,
    output       [roadf_pkg::sdram_aw-1:0]  sdram_addr,
    input                                   sdram_ack,
    input                                   data_dst,
    input                                   data_rdy,
    input        [15:0]                     data_read
);

import roadf_pkg::*;

// Each scroll address covers two SDRAM words
localparam logic [sdram_aw-1:0] scr_end = scr_start + (sdram_aw'(1) << (SCR_AW + 1));

logic                main_req, snd_req, scr_req;
logic                main_gnt, snd_gnt, scr_gnt;
logic [sdram_aw-1:0] main_raddr, snd_raddr, scr_raddr;

roadf_frac_cen u_cen(
    .clk        ( clk       ),
    .rst        ( rst       ),
    .vsync60    ( vsync60   ),
    .pxl2_cen   ( pxl2_cen  ),
    .pxl_cen    ( pxl_cen   )
);

roadf_dwnld #(
    .PROM_START ( prom_start ),
    .SCR_START  ( scr_start  ),
    .SCR_END    ( scr_end    )
) u_dwnld(
    .clk         ( clk          ),
    .rst         ( rst          ),
    .downloading ( downloading  ),
    .ioctl_addr  ( ioctl_addr   ),
    .ioctl_dout  ( ioctl_dout   ),
    .ioctl_wr    ( ioctl_wr     ),
    .sdram_ack   ( sdram_ack    ),
    .prog_addr   ( prog_addr    ),
    .prog_data   ( prog_data    ),
    .prog_mask   ( prog_mask    ),
    .prog_we     ( prog_we      ),
    .prom_we     ( prom_we      ),
    .dwnld_busy  ( dwnld_busy   )
);

roadf_rom_slot #(.AW(MAIN_AW), .OFFSET('0), .data_t(cpu_data_t)) u_main(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .cs        ( main_cs    ),
    .addr      ( main_addr  ),
    .data      ( main_data  ),
    .ok        ( main_ok    ),
    .req       ( main_req   ),
    .req_addr  ( main_raddr ),
    .gnt       ( main_gnt   ),
    .data_read ( data_read  ),
    .data_dst  ( data_dst   ),
    .data_rdy  ( data_rdy   )
);

roadf_rom_slot #(.AW(SND_AW), .OFFSET(snd_start), .data_t(cpu_data_t)) u_snd(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .cs        ( snd_cs     ),
    .addr      ( snd_addr   ),
    .data      ( snd_data   ),
    .ok        ( snd_ok     ),
    .req       ( snd_req    ),
    .req_addr  ( snd_raddr  ),
    .gnt       ( snd_gnt    ),
    .data_read ( data_read  ),
    .data_dst  ( data_dst   ),
    .data_rdy  ( data_rdy   )
);

roadf_rom_slot #(.AW(SCR_AW), .OFFSET(scr_start), .data_t(scr_data_t)) u_scr(
    .clk       ( clk        ),
    .rst       ( rst        ),
    .cs        ( scr_cs     ),
    .addr      ( scr_addr   ),
    .data      ( scr_data   ),
    .ok        ( scr_ok     ),
    .req       ( scr_req    ),
    .req_addr  ( scr_raddr  ),
    .gnt       ( scr_gnt    ),
    .data_read ( data_read  ),
    .data_dst  ( data_dst   ),
    .data_rdy  ( data_rdy   )
);

roadf_rom_arb u_arb(
    .clk         ( clk          ),
    .rst         ( rst          ),
    .downloading ( downloading  ),
    .main_req    ( main_req     ),
    .main_addr   ( main_raddr   ),
    .snd_req     ( snd_req      ),
    .snd_addr    ( snd_raddr    ),
    .scr_req     ( scr_req      ),
    .scr_addr    ( scr_raddr    ),
    .main_gnt    ( main_gnt     ),
    .snd_gnt     ( snd_gnt      ),
    .scr_gnt     ( scr_gnt      ),
    .sdram_req   ( sdram_req    ),
    .sdram_addr  ( sdram_addr   ),
    .sdram_ack   ( sdram_ack    ),
    .data_rdy    ( data_rdy     )
);

endmodule

/* test/roadf_clk_gen.sv */
`timescale 1ns/100ps

module roadf_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 16
)(
    output logic clk,
    output logic rst
);

initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;   // Released at the stimulus point
end

endmodule

/* test/roadf_sdram_model.sv */
`timescale 1ns/100ps

module roadf_sdram_model(
    input                                   clk,
    input                                   rst,
    input                                   sdram_req,
    input        [roadf_pkg::sdram_aw-1:0]  sdram_addr,
    output logic                            sdram_ack,
    output logic                            data_dst,
    output logic                            data_rdy,
    output logic [15:0]                     data_read,
    input                                   prog_we,
    input        [roadf_pkg::sdram_aw-1:0]  prog_addr,
    input        [7:0]                      prog_data,
    input        [1:0]                      prog_mask
);

import roadf_pkg::*;

typedef enum logic [2:0] {
    ph_idle,
    ph_read,
    ph_word0,
    ph_word1,
    ph_write,
    ph_gap
} phase_t;

phase_t              ph;
integer              seed;
int                  wait_cnt;
logic [sdram_aw-1:0] rd_addr;
logic                req_s;
logic                we_s;
logic [sdram_aw-1:0] addr_s;
logic [sdram_aw-1:0] paddr_s;
logic [7:0]          pdata_s;
logic [1:0]          pmask_s;
logic [15:0]         cur;
logic [sdram_aw-1:0] rd_log[$];   // Read addresses in the order served
logic [sdram_aw-1:0] wr_log[$];   // Programmed word addresses
logic [15:0]         wr_val[$];   // Word contents after each write

initial begin
    seed      = 32'he404_9e63;
    ph        = ph_idle;
    wait_cnt  = 0;
    sdram_ack = 1'b0;
    data_dst  = 1'b0;
    data_rdy  = 1'b0;
    data_read = '0;
end

// Unprogrammed words follow a fixed pattern of their address
function automatic logic [15:0] word_at(input logic [sdram_aw-1:0] a);
    logic [15:0] w;
    w = a[15:0] ^ 16'h5a5a;
    for (int i = 0; i < wr_log.size(); i++) begin
        if (wr_log[i] == a) begin
            w = wr_val[i];
        end
    end
    return w;
endfunction

always @(posedge clk) begin
    req_s   = sdram_req;    // Values from before the edge
    addr_s  = sdram_addr;
    we_s    = prog_we;
    paddr_s = prog_addr;
    pdata_s = prog_data;
    pmask_s = prog_mask;
    #2;
    sdram_ack = 1'b0;
    data_dst  = 1'b0;
    data_rdy  = 1'b0;
    if (rst) begin
        ph = ph_idle;
    end else begin
        case (ph)
            ph_idle: begin
                if (we_s) begin
                    wait_cnt = 1;   // Ack two cycles on
                    ph       = ph_write;
                end else if (req_s) begin
                    wait_cnt = $unsigned($random(seed)) % 4;
                    rd_addr  = addr_s;
                    rd_log.push_back(addr_s);
                    ph       = ph_read;
                end
            end
            ph_read: begin
                if (wait_cnt == 0) begin
                    sdram_ack = 1'b1;
                    ph        = ph_word0;
                end else begin
                    wait_cnt--;
                end
            end
            ph_word0: begin
                data_dst  = 1'b1;
                data_read = word_at(rd_addr);
                ph        = ph_word1;
            end
            ph_word1: begin
                data_dst  = 1'b1;
                data_rdy  = 1'b1;
                data_read = word_at(rd_addr + 1'b1);
                ph        = ph_idle;
            end
            ph_write: begin
                if (wait_cnt == 0) begin
                    sdram_ack = 1'b1;
                    cur = word_at(paddr_s);
                    if (!pmask_s[0]) cur[7:0]  = pdata_s;
                    if (!pmask_s[1]) cur[15:8] = pdata_s;
                    wr_log.push_back(paddr_s);
                    wr_val.push_back(cur);
                    ph = ph_gap;
                end else begin
                    wait_cnt--;
                end
            end
            default: ph = ph_idle;    // prog_we still high for this edge
        endcase
    end
end

endmodule

/* test/roadf_game_tb.sv */
`timescale 1ns/100ps

module roadf_game_tb;

import roadf_pkg::*;

// Tests take about 2300 cycles
localparam int TIMEOUT_CYCLES = 6000;
localparam int WAIT_LIMIT     = 40;

logic                clk;
logic                rst;
logic                vsync60;
logic                pxl2_cen;
logic                pxl_cen;
logic                downloading;
logic                dwnld_busy;
logic [ioctl_aw-1:0] ioctl_addr;
logic [7:0]          ioctl_dout;
logic                ioctl_wr;
logic [sdram_aw-1:0] prog_addr;
logic [7:0]          prog_data;
logic [1:0]          prog_mask;
logic                prog_we;
logic                prom_we;
logic                main_cs;
logic [15:0]         main_addr;
cpu_data_t           main_data;
logic                main_ok;
logic                snd_cs;
logic [12:0]         snd_addr;
cpu_data_t           snd_data;
logic                snd_ok;
logic                scr_cs;
logic [12:0]         scr_addr;
scr_data_t           scr_data;
logic                scr_ok;
logic                sdram_req;
logic [sdram_aw-1:0] sdram_addr;
logic                sdram_ack;
logic                data_dst;
logic                data_rdy;
logic [15:0]         data_read;

int errors;
int cycles;
int tests_run;
int tests_failed;

roadf_clk_gen #(.PERIOD(40), .RST_CYCLES(16)) u_clk(.clk(clk), .rst(rst));

roadf_game #(.MAIN_AW(16), .SND_AW(13), .SCR_AW(13)) dut(.*);

roadf_sdram_model u_sdram(.*);

task automatic check_cpu(input string name, input cpu_data_t got, input cpu_data_t exp);
    if (got !== exp) begin
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_scr(input string name, input scr_data_t got, input scr_data_t exp);
    if (got !== exp) begin
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_addr(input string name, input logic [sdram_aw-1:0] got,
                          input logic [sdram_aw-1:0] exp);
    if (got !== exp) begin
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_mask(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

function automatic logic [15:0] rom_word(input logic [sdram_aw-1:0] a);
    return a[15:0] ^ 16'h5a5a;
endfunction

// Byte 0 of a line is the low byte of its first word
function automatic cpu_data_t cpu_byte(input logic [sdram_aw-1:0] base, input logic [15:0] a);
    logic [sdram_aw-1:0] w0;
    logic [31:0]         line;
    w0   = base + 2 * (a >> 2);
    line = { rom_word(w0 + 1), rom_word(w0) };
    return line[8 * a[1:0] +: 8];
endfunction

function automatic scr_data_t scr_line(input logic [12:0] a);
    logic [sdram_aw-1:0] w0;
    w0 = scr_start + 2 * a;
    return { rom_word(w0 + 1), rom_word(w0) };
endfunction

function automatic logic [sdram_aw-1:0] prog_word(input logic [ioctl_aw-1:0] b);
    logic [sdram_aw-1:0] w;
    logic [3:0]          nib;
    w   = b >> 1;
    nib = w[3:0];
    // Scroll region holds 32kB
    if (w >= scr_start && w < scr_start + 22'h4000) begin
        w[3:0] = (nib << 1) | (nib < 4'h8 ? 4'h1 : 4'h0);   // Up one, old bit 3 inverted
    end
    return w;
endfunction

task automatic next_edge();
    @(posedge clk);
    #2;
endtask

task automatic wait_for_ok(input logic [2:0] need);
    int n;
    n = 0;
    @(negedge clk);
    while (({ scr_ok, snd_ok, main_ok } & need) != need && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (n >= WAIT_LIMIT) begin
        $display("Error: ok never came back for clients %b", need);
        errors++;
    end
endtask

task automatic report_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
        $display("test %s: passed", name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", name, errors - start);
    end
endtask

task automatic reset_values();
    int start;
    start = errors;
    @(negedge rst);
    @(negedge clk);
    check_bit("main_ok", main_ok, 1'b0);
    check_bit("snd_ok", snd_ok, 1'b0);
    check_bit("scr_ok", scr_ok, 1'b0);
    check_bit("sdram_req", sdram_req, 1'b0);
    check_bit("prog_we", prog_we, 1'b0);
    check_bit("prom_we", prom_we, 1'b0);
    check_bit("pxl2_cen", pxl2_cen, 1'b0);
    check_bit("pxl_cen", pxl_cen, 1'b0);
    report_test("reset", start);
endtask

task automatic cen_rates(input logic v60, input int n, input int m);
    int start;
    int c2;
    int c1;
    start = errors;
    next_edge();
    vsync60 = v60;
    repeat (4) next_edge();   // Let the new ratio settle
    c2 = 0;
    c1 = 0;
    repeat (1000) begin
        @(negedge clk);
        c2 += pxl2_cen;
        c1 += pxl_cen;
    end
    check_count("pxl2_cen pulses", c2, 1000 * n / m);
    check_count("pxl_cen pulses", c1, 1000 * n / m / 2);
    report_test($sformatf("cen %0d/%0d", n, m), start);
endtask

task automatic main_byte_read(input logic [15:0] a);
    int start;
    int reads;
    start = errors;
    next_edge();
    main_cs   = 1'b1;
    main_addr = a;
    wait_for_ok(3'b001);
    check_cpu("main_data", main_data, cpu_byte('0, a));
    reads = u_sdram.rd_log.size();
    check_addr("sdram_addr", u_sdram.rd_log[reads - 1], 2 * (a >> 2));
    next_edge();
    main_addr = a ^ 16'h0003;   // Other byte of the same line
    @(negedge clk);
    check_bit("main_ok", main_ok, 1'b1);
    check_cpu("main_data", main_data, cpu_byte('0, a ^ 16'h0003));
    repeat (4) begin
        @(negedge clk);
        check_bit("sdram_req", sdram_req, 1'b0);
    end
    check_count("sdram reads", u_sdram.rd_log.size(), reads);
    next_edge();
    main_cs = 1'b0;
    report_test($sformatf("main read %h", a), start);
endtask

task automatic scroll_word_read(input logic [12:0] a);
    int start;
    int reads;
    start = errors;
    next_edge();
    scr_cs   = 1'b1;
    scr_addr = a;
    wait_for_ok(3'b100);
    check_scr("scr_data", scr_data, scr_line(a));
    reads = u_sdram.rd_log.size();
    check_addr("sdram_addr", u_sdram.rd_log[reads - 1], scr_start + 2 * a);
    next_edge();
    scr_cs = 1'b0;
    report_test($sformatf("scroll read %h", a), start);
endtask

task automatic three_way_miss(input logic [15:0] ma, input logic [12:0] sa,
                              input logic [12:0] ca);
    int start;
    int base;
    start = errors;
    base  = u_sdram.rd_log.size();
    next_edge();
    main_cs   = 1'b1;
    main_addr = ma;
    snd_cs    = 1'b1;
    snd_addr  = sa;
    scr_cs    = 1'b1;
    scr_addr  = ca;
    wait_for_ok(3'b111);
    check_cpu("main_data", main_data, cpu_byte('0, ma));
    check_cpu("snd_data", snd_data, cpu_byte(snd_start, sa));
    check_scr("scr_data", scr_data, scr_line(ca));
    check_count("sdram reads", u_sdram.rd_log.size(), base + 3);
    if (u_sdram.rd_log.size() >= base + 3) begin
        check_addr("1st sdram_addr", u_sdram.rd_log[base], 2 * (ma >> 2));
        check_addr("2nd sdram_addr", u_sdram.rd_log[base + 1], snd_start + 2 * (sa >> 2));
        check_addr("3rd sdram_addr", u_sdram.rd_log[base + 2], scr_start + 2 * ca);
    end
    next_edge();
    main_cs = 1'b0;
    snd_cs  = 1'b0;
    scr_cs  = 1'b0;
    report_test("priority", start);
endtask

task automatic download_blocks_reads();
    int start;
    start = errors;
    next_edge();
    downloading = 1'b1;
    next_edge();
    main_cs   = 1'b1;
    main_addr = 16'h7777;   // Miss that would need the SDRAM
    repeat (20) begin
        @(negedge clk);
        check_bit("sdram_req", sdram_req, 1'b0);
        check_bit("dwnld_busy", dwnld_busy, 1'b1);
    end
    next_edge();
    main_cs = 1'b0;
    report_test("download blocks reads", start);
endtask

task automatic prog_byte_write(input logic [ioctl_aw-1:0] b, input logic [7:0] d);
    int start;
    int n;
    start = errors;
    next_edge();
    ioctl_addr = b;
    ioctl_dout = d;
    ioctl_wr   = 1'b1;
    next_edge();
    ioctl_wr = 1'b0;
    @(negedge clk);
    check_bit("prom_we", prom_we, 1'b0);
    check_addr("prog_addr", prog_addr, prog_word(b));
    check_mask("prog_mask", prog_mask, b[0] ? 2'b10 : 2'b01);
    check_cpu("prog_data", prog_data, d);
    n = 0;
    while (!sdram_ack && n < WAIT_LIMIT) begin
        check_bit("prog_we", prog_we, 1'b1);
        @(negedge clk);
        n++;
    end
    if (n >= WAIT_LIMIT) begin
        $display("Error: programming write at %h was never acknowledged", b);
        errors++;
    end
    check_bit("prog_we", prog_we, 1'b1);   // Still up in the ack cycle
    @(negedge clk);
    check_bit("prog_we", prog_we, 1'b0);
    n = u_sdram.wr_log.size();
    check_addr("written addr", u_sdram.wr_log[n - 1], prog_word(b));
    report_test($sformatf("prog write %h", b), start);
endtask

task automatic prom_byte_write(input logic [ioctl_aw-1:0] b, input logic [7:0] d);
    int start;
    start = errors;
    next_edge();
    ioctl_addr = b;
    ioctl_dout = d;
    ioctl_wr   = 1'b1;
    next_edge();
    ioctl_wr = 1'b0;
    @(negedge clk);
    check_bit("prom_we", prom_we, 1'b1);
    check_bit("prog_we", prog_we, 1'b0);
    @(negedge clk);
    check_bit("prom_we", prom_we, 1'b0);   // One cycle only
    check_bit("prog_we", prog_we, 1'b0);
    report_test($sformatf("prom write %h", b), start);
endtask

always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
        $display("Error: run stopped after %0d cycles without finishing", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end
end

initial begin
    vsync60      = 1'b1;
    downloading  = 1'b0;
    ioctl_addr   = '0;
    ioctl_dout   = '0;
    ioctl_wr     = 1'b0;
    main_cs      = 1'b0;
    main_addr    = '0;
    snd_cs       = 1'b0;
    snd_addr     = '0;
    scr_cs       = 1'b0;
    scr_addr     = '0;
    errors       = 0;
    cycles       = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_values();
    cen_rates(1'b1, 1, 4);
    cen_rates(1'b0, 32, 125);
    main_byte_read(16'h1235);
    main_byte_read(16'h0a42);
    scroll_word_read(13'h0004);
    scroll_word_read(13'h1fff);
    three_way_miss(16'h4003, 13'h0105, 13'h0021);
    download_blocks_reads();
    prog_byte_write(25'h00_1234, 8'ha5);
    prog_byte_write(25'h00_1235, 8'h3c);
    prog_byte_write(25'h01_0010, 8'h77);   // Sound region, no rotation
    prog_byte_write(25'h01_2006, 8'he1);
    prog_byte_write(25'h01_9fff, 8'h0f);   // Last scroll byte
    prom_byte_write(prom_start + 25'h005, 8'h5c);
    prom_byte_write(prom_start + 25'h100, 8'hc3);
    next_edge();
    downloading = 1'b0;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

/* roadf_rom.f */
verilog/roadf_pkg.sv
verilog/roadf_frac_cen.sv
verilog/roadf_dwnld.sv
verilog/roadf_rom_slot.sv
verilog/roadf_rom_arb.sv
verilog/roadf_game.sv
test/roadf_clk_gen.sv
test/roadf_sdram_model.sv
test/roadf_game_tb.sv

/* Bender.yml */
package:
  name: roadf_rom

sources:
  - files:
      - verilog/roadf_pkg.sv
      - verilog/roadf_frac_cen.sv
      - verilog/roadf_dwnld.sv
      - verilog/roadf_rom_slot.sv
      - verilog/roadf_rom_arb.sv
      - verilog/roadf_game.sv
  - target: test
    files:
      - test/roadf_clk_gen.sv
      - test/roadf_sdram_model.sv
      - test/roadf_game_tb.sv
